//--- tb.f
rtl/cpu_pkg.sv
rtl/mem_pkg.sv
rtl/pipe_reg.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mem_wb_top.sv
test/mem_wb_sva.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f tb.f \
	--top-module tb_top \
	-Mdir obj_dir \
	-o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

//--- test/tb_top.sv
`timescale 1ns/1ns

module tb_top;

	import cpu_pkg::*;
	import mem_pkg::*;

	localparam int period     = 100;
	localparam int init_words = 32;
	localparam int rand_items = 200;
	localparam int n_items    = init_words + rand_items;
	localparam int seed_init  = 56817;

	logic      clk;
	logic      reset;
	logic      in_valid;
	logic      in_ready;
	exe_mem_t  in_item;
	logic      ret_valid;
	logic      ret_ready;
	mem_wb_t   ret_item;
	bypass_t   early_byp;
	bypass_t   late_byp;
	reg_addr_t rs_addr;
	xdata_t    rs_data;

	integer    seed;
	integer    rdy_seed;
	logic      rnd_phase;

	// model state
	xdata_t    mem_model [int];
	xdata_t    reg_model [32];
	mem_wb_t   exp_q [$];
	exe_mem_t  src_q [$];
	logic      em_full;
	logic      mw_full;
	reg_addr_t last_rd;
	int        retired;
	int        cyc;
	int        first_acc;

	mem_wb_top u_dut (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_item   (in_item),
		.ret_valid (ret_valid),
		.ret_ready (ret_ready),
		.ret_item  (ret_item),
		.early_byp (early_byp),
		.late_byp  (late_byp),
		.rs_addr   (rs_addr),
		.rs_data   (rs_data)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_item(input string name, input mem_wb_t exp, input mem_wb_t act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			abort_run("retire item mismatch");
		end
	endtask

	// rd and data only matter when the expected we is set
	task automatic check_bypass(input string name, input bypass_t exp, input bypass_t act);
		if (exp.we !== act.we || (exp.we && (exp.rd !== act.rd || exp.data !== act.data))) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			abort_run("bypass mismatch");
		end
	endtask

	task automatic check_reg(input string name, input xdata_t exp, input xdata_t act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			abort_run("register read mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			abort_run("control signal mismatch");
		end
	endtask

	function automatic bypass_t make_byp(input logic valid, input mem_wb_t it);
		bypass_t b;
		b.we   = valid && it.reg_we;
		b.rd   = it.rd;
		b.data = it.wb_data;
		return b;
	endfunction

	// byte-wise memory model, loads and stores in acceptance order
	function automatic mem_wb_t ref_item(input exe_mem_t it);
		mem_wb_t    r;
		logic [2:0] f3;
		int         idx;
		int         off;
		int         nbytes;
		xdata_t     w;
		xdata_t     v;
		f3     = it.ins[14:12];
		idx    = {{(32 - mem_idx_w){1'b0}}, it.alu_result[mem_idx_w+2:3]};
		off    = {29'd0, it.alu_result[2:0]};
		nbytes = 1 << f3[1:0];
		w      = mem_model.exists(idx) ? mem_model[idx] : 'x;
		r.pc      = it.pc;
		r.ins     = it.ins;
		r.rd      = it.rd;
		r.reg_we  = it.reg_we;
		r.wb_data = it.alu_result;
		if (it.mem_we) begin
			for (int b = 0; b < nbytes; b++) begin
				w[(off + b) * 8 +: 8] = it.store_data[b * 8 +: 8];
			end
			mem_model[idx] = w;
		end
		if (it.wb_sel) begin
			v = '0;
			for (int b = 0; b < nbytes; b++) begin
				v[b * 8 +: 8] = w[(off + b) * 8 +: 8];
			end
			if (!f3[2]) begin
				for (int b = nbytes * 8; b < xlen; b++) begin
					v[b] = v[nbytes * 8 - 1];
				end
			end
			r.wb_data = v;
		end
		return r;
	endfunction

	function automatic exe_mem_t store_dword(input logic [4:0] idx);
		exe_mem_t it;
		it.pc         = {$random(seed), $random(seed)};
		it.ins        = $random(seed);
		it.ins[14:12] = {1'b0, size_d};
		it.alu_result = {52'd0, 4'd0, idx, 3'd0};
		it.store_data = {$random(seed), $random(seed)};
		it.rd         = 5'd0;
		it.reg_we     = 1'b0;
		it.mem_we     = 1'b1;
		it.wb_sel     = 1'b0;
		return it;
	endfunction

	function automatic exe_mem_t gen_item();
		exe_mem_t    it;
		logic [31:0] r;
		mem_size_t   sz;
		logic [2:0]  off;
		r   = $random(seed);
		sz  = mem_size_t'(r[3:2]);
		off = r[11:9];
		case (sz)
			size_h: off[0] = 1'b0;
			size_w: off[1:0] = 2'b00;
			size_d: off = 3'b000;
			default: ;
		endcase
		it.pc         = {$random(seed), $random(seed)};
		it.ins        = $random(seed);
		it.alu_result = {$random(seed), $random(seed)};
		it.store_data = {$random(seed), $random(seed)};
		it.rd         = r[17:13];
		it.reg_we     = r[18];
		it.mem_we     = 1'b0;
		it.wb_sel     = 1'b0;
		if (r[1:0] == 2'd1) begin
			it.ins[14:12] = {1'b0, sz};
			it.alu_result = {52'd0, 4'd0, r[8:4], off};
			it.reg_we     = 1'b0;
			it.mem_we     = 1'b1;
		end else if (r[1]) begin
			// no unsigned double load
			it.ins[14]    = r[12] && (sz != size_d);
			it.ins[13:12] = sz;
			it.alu_result = {52'd0, 4'd0, r[8:4], off};
			it.reg_we     = 1'b1;
			it.wb_sel     = 1'b1;
		end
		return it;
	endfunction

	task automatic send_item(input exe_mem_t it);
		@(negedge clk);
		in_valid = 1'b1;
		in_item  = it;
		@(posedge clk);
		while (!in_ready) @(posedge clk);
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		in_valid = 1'b0;
		in_item  = gen_item();
	endtask

	// stimulus
	initial begin
		logic [31:0] r;
		reset     = 1'b1;
		in_valid  = 1'b0;
		in_item   = '0;
		seed      = seed_init;
		rnd_phase = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// no traffic for a while
		repeat (4) @(negedge clk);
		for (int i = 0; i < init_words; i++) begin
			send_item(store_dword(i[4:0]));
		end
		rnd_phase = 1'b1;
		for (int i = 0; i < rand_items; i++) begin
			r = $random(seed);
			if (r[2:0] == 3'd0) begin
				idle_cycle();
			end
			send_item(gen_item());
		end
		@(negedge clk);
		in_valid = 1'b0;
		wait (retired == n_items);
		repeat (2) @(posedge clk);
		if (ret_valid !== 1'b0) begin
			abort_run("items remain in flight after the last retire");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

	// retire back-pressure, held high until the random phase
	initial begin
		logic [31:0] r;
		ret_ready = 1'b0;
		rdy_seed  = seed_init + 1;
		forever begin
			@(negedge clk);
			if (!rnd_phase) begin
				ret_ready = 1'b1;
			end else begin
				r = $random(rdy_seed);
				ret_ready = (r[1:0] != 2'b00);
			end
		end
	end

	// read back the register that retired last
	initial begin
		rs_addr = '0;
		forever begin
			@(negedge clk);
			rs_addr = last_rd;
		end
	end

	// compare against a cycle model of the two stage registers
	initial begin : compare
		mem_wb_t head;
		logic    exp_rdy;
		logic    move;
		logic    retire;
		logic    accept;
		int      em_i;
		em_full   = 1'b0;
		mw_full   = 1'b0;
		last_rd   = '0;
		retired   = 0;
		cyc       = 0;
		first_acc = -1;
		for (int i = 0; i < 32; i++) begin
			reg_model[i] = '0;
		end
		forever begin
			@(posedge clk);
			cyc++;
			if (reset) begin
				em_full = 1'b0;
				mw_full = 1'b0;
			end else begin
				exp_rdy = !em_full || !mw_full || ret_ready;
				move    = em_full && (!mw_full || ret_ready);
				retire  = mw_full && ret_ready;
				accept  = in_valid && exp_rdy;
				em_i    = mw_full ? 1 : 0;
				check_bit("in_ready", exp_rdy, in_ready);
				check_bit("ret_valid", mw_full, ret_valid);
				check_reg("rs_data", reg_model[rs_addr], rs_data);
				// the first item is on the retire port two edges after acceptance
				if (first_acc >= 0 && cyc == first_acc + 2) begin
					check_bit("ret_valid", 1'b1, ret_valid);
				end
				if (mw_full) begin
					check_item("ret_item", exp_q[0], ret_item);
					check_bypass("late_byp", make_byp(1'b1, exp_q[0]), late_byp);
				end else begin
					check_bypass("late_byp", make_byp(1'b0, '0), late_byp);
				end
				if (em_full) begin
					check_bypass("early_byp", make_byp(1'b1, exp_q[em_i]), early_byp);
					check_bit("ram_we", move && src_q[em_i].mem_we, u_dut.ram_we);
				end else begin
					check_bypass("early_byp", make_byp(1'b0, '0), early_byp);
					check_bit("ram_we", 1'b0, u_dut.ram_we);
				end
				if (retire) begin
					head = exp_q.pop_front();
					src_q.delete(0);
					if (head.reg_we && head.rd != 5'd0) begin
						reg_model[head.rd] = head.wb_data;
					end
					last_rd = head.rd;
					retired++;
				end
				if (accept) begin
					if (first_acc < 0) begin
						first_acc = cyc;
					end
					exp_q.push_back(ref_item(in_item));
					src_q.push_back(in_item);
				end
				mw_full = move || (mw_full && !ret_ready);
				em_full = accept || (em_full && !move);
			end
		end
	end

	initial begin
		repeat (n_items * 20 + 100) @(posedge clk);
		abort_run("timeout, not all items retired in time");
	end

endmodule

//--- test/mem_wb_sva.sv
`timescale 1ns/1ns

module mem_wb_sva (
	input logic             clk,
	input logic             reset,
	input logic             in_ready,
	input logic             ret_valid,
	input logic             ret_ready,
	input cpu_pkg::mem_wb_t ret_item
);

	// a stalled retire item stays put
	property hold_while_stalled;
		@(posedge clk) disable iff (reset)
		ret_valid && !ret_ready |=> ret_valid && $stable(ret_item);
	endproperty

	a_hold: assert property (hold_while_stalled)
		else $error("retire item dropped or changed while stalled");

	a_reset_valid: assert property (@(posedge clk) reset |=> !ret_valid)
		else $error("ret_valid high after reset");

	// both stage registers are empty after reset
	a_reset_ready: assert property (@(posedge clk) reset |=> in_ready)
		else $error("in_ready low after reset");

endmodule

bind mem_wb_top mem_wb_sva u_sva (
	.clk       (clk),
	.reset     (reset),
	.in_ready  (in_ready),
	.ret_valid (ret_valid),
	.ret_ready (ret_ready),
	.ret_item  (ret_item)
);

//--- rtl/mem_wb_top.sv
`timescale 1ns/1ns

module mem_wb_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	output logic               in_ready,
	input  cpu_pkg::exe_mem_t  in_item,
	output logic               ret_valid,
	input  logic               ret_ready,
	output cpu_pkg::mem_wb_t   ret_item,
	output cpu_pkg::bypass_t   early_byp,
	output cpu_pkg::bypass_t   late_byp,
	input  cpu_pkg::reg_addr_t rs_addr,
	output cpu_pkg::xdata_t    rs_data
);

	import cpu_pkg::*;
	import mem_pkg::*;

	logic     em_valid;
	logic     em_ready;
	exe_mem_t em_item;
	mem_wb_t  mw_next;
	logic     mw_valid;
	logic     mw_ready;
	mem_wb_t  mw_item;
	logic     mem_fire;

	logic [mem_idx_w-1:0] ram_idx;
	xdata_t               ram_rdata;
	logic                 ram_we;
	xdata_t               ram_wdata;
	byte_mask_t           ram_mask;

	// handshake into the memory/write-back register
	assign mem_fire = em_valid && em_ready;

	pipe_reg #(.payload_t(exe_mem_t)) u_exe_mem (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_item),
		.out_valid (em_valid),
		.out_ready (em_ready),
		.out_data  (em_item)
	);

	mem_stage u_mem_stage (
		.in_item   (em_item),
		.in_valid  (em_valid),
		.in_fire   (mem_fire),
		.ram_idx   (ram_idx),
		.ram_rdata (ram_rdata),
		.ram_we    (ram_we),
		.ram_wdata (ram_wdata),
		.ram_mask  (ram_mask),
		.out_item  (mw_next),
		.early_byp (early_byp)
	);

	data_ram u_data_ram (
		.clk     (clk),
		.rd_idx  (ram_idx),
		.rd_data (ram_rdata),
		.we      (ram_we),
		.wr_idx  (ram_idx),
		.wr_data (ram_wdata),
		.wr_mask (ram_mask)
	);

	pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (em_valid),
		.in_ready  (em_ready),
		.in_data   (mw_next),
		.out_valid (mw_valid),
		.out_ready (mw_ready),
		.out_data  (mw_item)
	);

	wb_stage u_wb_stage (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (mw_valid),
		.in_ready  (mw_ready),
		.in_item   (mw_item),
		.ret_valid (ret_valid),
		.ret_ready (ret_ready),
		.ret_item  (ret_item),
		.late_byp  (late_byp),
		.rs_addr   (rs_addr),
		.rs_data   (rs_data)
	);

endmodule

//--- rtl/wb_stage.sv
`timescale 1ns/1ns

module wb_stage (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	output logic               in_ready,
	input  cpu_pkg::mem_wb_t   in_item,
	output logic               ret_valid,
	input  logic               ret_ready,
	output cpu_pkg::mem_wb_t   ret_item,
	output cpu_pkg::bypass_t   late_byp,
	input  cpu_pkg::reg_addr_t rs_addr,
	output cpu_pkg::xdata_t    rs_data
);

	import cpu_pkg::*;

	xdata_t regs [1:31];
	logic   retire;

	// retire port follows the memory/write-back register directly
	assign ret_valid = in_valid;
	assign ret_item  = in_item;
	assign in_ready  = ret_ready;
	assign retire    = in_valid && ret_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (retire && in_item.reg_we && (in_item.rd != '0)) begin
			regs[in_item.rd] <= in_item.wb_data;
		end
	end

	// x0 is hardwired
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

	always_comb begin
		late_byp.we   = in_item.reg_we && in_valid;
		late_byp.rd   = in_item.rd;
		late_byp.data = in_item.wb_data;
	end

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
	input  cpu_pkg::exe_mem_t             in_item,
	input  logic                          in_valid,
	input  logic                          in_fire,
	output logic [mem_pkg::mem_idx_w-1:0] ram_idx,
	input  cpu_pkg::xdata_t               ram_rdata,
	output logic                          ram_we,
	output cpu_pkg::xdata_t               ram_wdata,
	output mem_pkg::byte_mask_t           ram_mask,
	output cpu_pkg::mem_wb_t              out_item,
	output cpu_pkg::bypass_t              early_byp
);

	import cpu_pkg::*;
	import mem_pkg::*;

	mem_size_t size;
	logic      uns;
	logic [2:0] offset;
	logic [5:0] shamt;
	xdata_t    lane;
	xdata_t    load_val;
	xdata_t    wb_data;

	assign size   = access_size(in_item.ins);
	assign uns    = is_unsigned(in_item.ins);
	assign offset = in_item.alu_result[2:0];
	assign shamt  = {offset, 3'b000};

	// word index drops the byte offset bits
	assign ram_idx = in_item.alu_result[mem_idx_w+2:3];

	// store path
	assign ram_we    = in_item.mem_we && in_fire;
	assign ram_wdata = in_item.store_data << shamt;
	assign ram_mask  = size_mask(size) << offset;

	// load path, lane moved down to bit 0 first
	assign lane = ram_rdata >> shamt;

	always_comb begin
		case (size)
			size_b: begin
				if (uns) begin
					load_val = {{(xlen-8){1'b0}}, lane[7:0]};
				end else begin
					load_val = {{(xlen-8){lane[7]}}, lane[7:0]};
				end
			end
			size_h: begin
				if (uns) begin
					load_val = {{(xlen-16){1'b0}}, lane[15:0]};
				end else begin
					load_val = {{(xlen-16){lane[15]}}, lane[15:0]};
				end
			end
			size_w: begin
				if (uns) begin
					load_val = {{(xlen-32){1'b0}}, lane[31:0]};
				end else begin
					load_val = {{(xlen-32){lane[31]}}, lane[31:0]};
				end
			end
			default: begin
				load_val = lane;
			end
		endcase
	end

	assign wb_data = in_item.wb_sel ? load_val : in_item.alu_result;

	always_comb begin
		out_item.pc      = in_item.pc;
		out_item.ins     = in_item.ins;
		out_item.rd      = in_item.rd;
		out_item.reg_we  = in_item.reg_we;
		out_item.wb_data = wb_data;
	end

	// early forward carries the final write-back value
	always_comb begin
		early_byp.we   = in_item.reg_we && in_valid;
		early_byp.rd   = in_item.rd;
		early_byp.data = wb_data;
	end

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/1ns

module data_ram (
	input  logic                         clk,
	input  logic [mem_pkg::mem_idx_w-1:0] rd_idx,
	output cpu_pkg::xdata_t               rd_data,
	input  logic                         we,
	input  logic [mem_pkg::mem_idx_w-1:0] wr_idx,
	input  cpu_pkg::xdata_t               wr_data,
	input  mem_pkg::byte_mask_t           wr_mask
);

	import cpu_pkg::*;
	import mem_pkg::*;

	xdata_t mem [mem_words];

	assign rd_data = mem[rd_idx];

	// only masked byte lanes are touched
	always_ff @(posedge clk) begin
		if (we) begin
			for (int i = 0; i < 8; i++) begin
				if (wr_mask[i]) begin
					mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
				end
			end
		end
	end

endmodule

//--- rtl/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic load;

	// take a new item when empty or when the held one leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign load     = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_data <= in_data;
		end
	end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

	localparam int mem_words = 512;
	localparam int mem_idx_w = 9;

	// matches funct3[1:0] of the load/store opcodes
	typedef enum logic [1:0] {
		size_b = 2'd0,
		size_h = 2'd1,
		size_w = 2'd2,
		size_d = 2'd3
	} mem_size_t;

	typedef logic [7:0] byte_mask_t;

	function automatic mem_size_t access_size(input cpu_pkg::ins_t ins);
		return mem_size_t'(ins[13:12]);
	endfunction

	// funct3[2] marks lbu/lhu/lwu
	function automatic logic is_unsigned(input cpu_pkg::ins_t ins);
		return ins[14];
	endfunction

	function automatic byte_mask_t size_mask(input mem_size_t size);
		case (size)
			size_b: return 8'h01;
			size_h: return 8'h03;
			size_w: return 8'h0f;
			default: return 8'hff;
		endcase
	endfunction

endpackage

//--- rtl/cpu_pkg.sv
package cpu_pkg;

	localparam int xlen   = 64;
	localparam int addr_w = 64;

	typedef logic [4:0]        reg_addr_t;
	typedef logic [31:0]       ins_t;
	typedef logic [xlen-1:0]   xdata_t;

	// execute to memory payload
	typedef struct packed {
		logic [addr_w-1:0] pc;
		ins_t              ins;
		xdata_t            alu_result;
		xdata_t            store_data;
		reg_addr_t         rd;
		logic              reg_we;
		logic              mem_we;
		// 0 takes alu_result, 1 takes load data
		logic              wb_sel;
	} exe_mem_t;

	// memory to write-back payload
	typedef struct packed {
		logic [addr_w-1:0] pc;
		ins_t              ins;
		reg_addr_t         rd;
		logic              reg_we;
		xdata_t            wb_data;
	} mem_wb_t;

	// forwarding value seen by decode
	typedef struct packed {
		logic      we;
		reg_addr_t rd;
		xdata_t    data;
	} bypass_t;

endpackage
